// ==== ciPkg.sv ====
package ciPkg;

  typedef logic [31:0] word_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [1:0]  unitSel_t;

  // custom-instruction numbers.
  localparam opcode_t SWAP_ID    = 8'h01;
  localparam opcode_t PROFILE_ID = 8'h0B;
  localparam opcode_t GRAY_ID    = 8'h0C;

  // unit chosen by decode.
  localparam unitSel_t UNIT_NONE    = 2'd0;
  localparam unitSel_t UNIT_SWAP    = 2'd1;
  localparam unitSel_t UNIT_PROFILE = 2'd2;
  localparam unitSel_t UNIT_GRAY    = 2'd3;

  // cycles, stall cycles, bus-idle cycles.
  localparam int NUM_COUNTERS = 3;

  // top bit set after 16 clocks.
  localparam int RESET_COUNT_BITS = 5;

  // luminance weights adding up to 256.
  localparam logic [7:0] GRAY_RED_WEIGHT   = 8'd54;
  localparam logic [7:0] GRAY_GREEN_WEIGHT = 8'd183;
  localparam logic [7:0] GRAY_BLUE_WEIGHT  = 8'd19;

endpackage

// ==== ciIssueIf.sv ====
`timescale 1ns/1ns

interface ciIssueIf;

  logic             req;
  logic             ack;
  ciPkg::unitSel_t  unitSel;
  ciPkg::word_t     operandA;
  ciPkg::word_t     operandB;

  // payload is stable while req is high.
  modport source (
    output req,
    output unitSel,
    output operandA,
    output operandB,
    input  ack
  );

  modport sink (
    input  req,
    input  unitSel,
    input  operandA,
    input  operandB,
    output ack
  );

endinterface

// ==== resetSequencer.sv ====
`timescale 1ns/1ns

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreResetN,
  output logic peripheralResetN
);

  localparam int TOP_BIT = ciPkg::RESET_COUNT_BITS - 1;

  logic [ciPkg::RESET_COUNT_BITS-1:0] resetCount;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[TOP_BIT]) begin
      resetCount <= resetCount + 1'b1; // stops once the top bit sets.
    end
  end

  assign coreResetN       = resetCount[TOP_BIT];
  assign peripheralResetN = resetCount[TOP_BIT];

endmodule

// ==== profileCounters.sv ====
`timescale 1ns/1ns

module profileCounters (
  input  logic          s_systemClock,
  input  logic          coreResetN,
  input  logic          cpuStall,
  input  logic          busIdle,
  input  ciPkg::word_t  control,
  input  logic          controlStrobe,
  input  logic [1:0]    select,
  output ciPkg::word_t  counterValue
);

  localparam int N = ciPkg::NUM_COUNTERS;

  ciPkg::word_t   counters [N];
  logic [N-1:0]   events;
  logic [N-1:0]   enables;
  logic [N-1:0]   enableBits;
  logic [N-1:0]   disableBits;
  logic [N-1:0]   clearBits;

  assign events = {busIdle, cpuStall, 1'b1}; // counter 0 counts every cycle.

  assign enableBits  = controlStrobe ? control[0 +: N] : '0;
  assign disableBits = controlStrobe ? control[4 +: N] : '0;
  assign clearBits   = controlStrobe ? control[8 +: N] : '0;

  always_ff @(posedge s_systemClock or negedge coreResetN) begin
    if (!coreResetN) begin
      enables <= '0;
    end else begin
      enables <= (enables | enableBits) & ~disableBits; // disable wins.
    end
  end

  always_ff @(posedge s_systemClock or negedge coreResetN) begin
    if (!coreResetN) begin
      for (int i = 0; i < N; i++) begin
        counters[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        if (clearBits[i]) begin
          counters[i] <= '0;
        end else if (enables[i] && events[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    counterValue = '0; // select 3 has no counter.
    for (int i = 0; i < N; i++) begin
      if (select == 2'(i)) counterValue = counters[i];
    end
  end

endmodule

// ==== ciDecodeStage.sv ====
`timescale 1ns/1ns

module ciDecodeStage (
  input  logic             s_systemClock,
  input  logic             coreResetN,
  input  logic             ciReq,
  input  ciPkg::opcode_t   ciOpcode,
  input  ciPkg::word_t     ciDataA,
  input  ciPkg::word_t     ciDataB,
  ciIssueIf.source         issue
);

  typedef enum logic [1:0] {
    decodeIdle,
    decodeIssue,
    decodeWaitRelease
  } decodeState_t;

  decodeState_t    state;
  ciPkg::unitSel_t decodedUnit;
  logic            accept;

  always_comb begin
    case (ciOpcode)
      ciPkg::SWAP_ID:    decodedUnit = ciPkg::UNIT_SWAP;
      ciPkg::PROFILE_ID: decodedUnit = ciPkg::UNIT_PROFILE;
      ciPkg::GRAY_ID:    decodedUnit = ciPkg::UNIT_GRAY;
      default:           decodedUnit = ciPkg::UNIT_NONE; // nobody claims it.
    endcase
  end

  // previous issue must be fully released first.
  assign accept = (state == decodeIdle) && ciReq && !issue.ack;

  always_ff @(posedge s_systemClock or negedge coreResetN) begin
    if (!coreResetN) begin
      state <= decodeIdle;
    end else begin
      case (state)
        decodeIdle:        if (accept) state <= decodeIssue;
        decodeIssue:       if (issue.ack) state <= decodeWaitRelease;
        decodeWaitRelease: if (!ciReq) state <= decodeIdle; // requester saw its ack.
        default:           state <= decodeIdle;
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (accept) begin
      issue.unitSel  <= decodedUnit;
      issue.operandA <= ciDataA;
      issue.operandB <= ciDataB;
    end
  end

  assign issue.req = (state == decodeIssue);

endmodule

// ==== ciExecuteStage.sv ====
`timescale 1ns/1ns

module ciExecuteStage (
  input  logic          s_systemClock,
  input  logic          coreResetN,
  input  logic          cpuStall,
  input  logic          busIdle,
  input  logic          resultAck,
  ciIssueIf.sink        issue,
  output logic          resultReq,
  output ciPkg::word_t  resultWord
);

  typedef enum logic [1:0] {
    execIdle,
    execResult,
    execRelease
  } execState_t;

  execState_t    state;
  logic          issueSeen;
  ciPkg::word_t  swapValue;
  ciPkg::word_t  counterValue;
  ciPkg::word_t  unitResult;
  logic [15:0]   graySum;

  assign issueSeen = (state == execIdle) && issue.req;

  // bit 0 of B picks half-word swap over full reversal.
  assign swapValue = issue.operandB[0] ?
    {issue.operandA[23:16], issue.operandA[31:24], issue.operandA[7:0], issue.operandA[15:8]} :
    {issue.operandA[7:0], issue.operandA[15:8], issue.operandA[23:16], issue.operandA[31:24]};

  // channels widened to 8 bits before weighting.
  assign graySum = ciPkg::GRAY_RED_WEIGHT * {8'd0, issue.operandA[15:11], 3'd0} +
                   ciPkg::GRAY_GREEN_WEIGHT * {8'd0, issue.operandA[10:5], 2'd0} +
                   ciPkg::GRAY_BLUE_WEIGHT * {8'd0, issue.operandA[4:0], 3'd0};

  profileCounters counters0 (
    .s_systemClock (s_systemClock),
    .coreResetN    (coreResetN),
    .cpuStall      (cpuStall),
    .busIdle       (busIdle),
    .control       (issue.operandB),
    .controlStrobe (issueSeen && (issue.unitSel == ciPkg::UNIT_PROFILE)),
    .select        (issue.operandA[1:0]),
    .counterValue  (counterValue)
  );

  always_comb begin
    case (issue.unitSel)
      ciPkg::UNIT_SWAP:    unitResult = swapValue;
      ciPkg::UNIT_GRAY:    unitResult = {24'd0, graySum[15:8]};
      ciPkg::UNIT_PROFILE: unitResult = counterValue; // value before the strobe.
      default:             unitResult = '0;
    endcase
  end

  always_ff @(posedge s_systemClock or negedge coreResetN) begin
    if (!coreResetN) begin
      state     <= execIdle;
      resultReq <= 1'b0;
      issue.ack <= 1'b0;
    end else begin
      case (state)
        execIdle: begin
          if (issue.req) begin
            resultReq <= 1'b1;
            issue.ack <= 1'b1;
            state     <= execResult;
          end
        end
        execResult: begin
          if (resultAck) begin
            resultReq <= 1'b0;
            state     <= execRelease;
          end
        end
        execRelease: begin
          // ack held until both handshakes are back to zero.
          if (!resultAck && !issue.req) begin
            issue.ack <= 1'b0;
            state     <= execIdle;
          end
        end
        default: state <= execIdle;
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (issueSeen) resultWord <= unitResult;
  end

endmodule

// ==== ciResponseStage.sv ====
`timescale 1ns/1ns

module ciResponseStage (
  input  logic          s_systemClock,
  input  logic          coreResetN,
  input  logic          ciReq,
  input  logic          resultReq,
  input  ciPkg::word_t  resultWord,
  output logic          resultAck,
  output logic          ciAck,
  output ciPkg::word_t  ciResult
);

  typedef enum logic [1:0] {
    respIdle,
    respAcked,
    respRelease
  } respState_t;

  respState_t state;

  always_ff @(posedge s_systemClock or negedge coreResetN) begin
    if (!coreResetN) begin
      state     <= respIdle;
      ciAck     <= 1'b0;
      resultAck <= 1'b0;
      ciResult  <= '0;
    end else begin
      case (state)
        respIdle: begin
          if (resultReq) begin
            ciResult <= resultWord;
            ciAck    <= 1'b1;
            state    <= respAcked;
          end
        end
        respAcked: begin
          if (!ciReq) begin // back-pressure ends here.
            ciAck     <= 1'b0;
            resultAck <= 1'b1;
            state     <= respRelease;
          end
        end
        respRelease: begin
          if (!resultReq) begin
            resultAck <= 1'b0;
            state     <= respIdle;
          end
        end
        default: state <= respIdle;
      endcase
    end
  end

endmodule

// ==== ciAccelTop.sv ====
`timescale 1ns/1ns

module ciAccelTop (
  input  logic            s_systemClock,
  input  logic            s_pllLocked,
  input  logic            ciReq,
  input  logic            cpuStall,
  input  logic            busIdle,
  input  ciPkg::opcode_t  ciOpcode,
  input  ciPkg::word_t    ciDataA,
  input  ciPkg::word_t    ciDataB,
  output logic            ciAck,
  output logic            peripheralResetN,
  output ciPkg::word_t    ciResult
);

  logic          coreResetN;
  logic          resultReq;
  logic          resultAck;
  ciPkg::word_t  resultWord;

  ciIssueIf issueBus ();

  resetSequencer sequencer0 (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .coreResetN       (coreResetN),
    .peripheralResetN (peripheralResetN)
  );

  ciDecodeStage decode0 (
    .s_systemClock (s_systemClock),
    .coreResetN    (coreResetN),
    .ciReq         (ciReq),
    .ciOpcode      (ciOpcode),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .issue         (issueBus.source)
  );

  ciExecuteStage execute0 (
    .s_systemClock (s_systemClock),
    .coreResetN    (coreResetN),
    .cpuStall      (cpuStall),
    .busIdle       (busIdle),
    .resultAck     (resultAck),
    .issue         (issueBus.sink),
    .resultReq     (resultReq),
    .resultWord    (resultWord)
  );

  ciResponseStage response0 (
    .s_systemClock (s_systemClock),
    .coreResetN    (coreResetN),
    .ciReq         (ciReq),
    .resultReq     (resultReq),
    .resultWord    (resultWord),
    .resultAck     (resultAck),
    .ciAck         (ciAck),
    .ciResult      (ciResult)
  );

endmodule

// ==== tbCiAccel.sv ====
`timescale 1ns/1ns

module tbCiAccel;

  localparam int ACK_TIMEOUT = 64;

  logic            s_systemClock;
  logic            s_pllLocked;
  logic            ciReq;
  logic            cpuStall;
  logic            busIdle;
  ciPkg::opcode_t  ciOpcode;
  ciPkg::word_t    ciDataA;
  ciPkg::word_t    ciDataB;
  logic            ciAck;
  logic            peripheralResetN;
  ciPkg::word_t    ciResult;
  int              seed;

  ciAccelTop dut0 (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .ciReq            (ciReq),
    .cpuStall         (cpuStall),
    .busIdle          (busIdle),
    .ciOpcode         (ciOpcode),
    .ciDataA          (ciDataA),
    .ciDataB          (ciDataB),
    .ciAck            (ciAck),
    .peripheralResetN (peripheralResetN),
    .ciResult         (ciResult)
  );

  always #4 s_systemClock = ~s_systemClock; // 8 ns period.

  task automatic abortRun();
    $display("Something failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic checkValue(input string testName, input ciPkg::word_t expected,
                            input ciPkg::word_t actual);
    assert (actual === expected) else begin
      $display("error %s expected %h actual %h", testName, expected, actual);
      abortRun();
    end
  endtask

  // byte i moves to byte i^3 for reversal, i^1 for half-word swap.
  function automatic ciPkg::word_t swapRule(input ciPkg::word_t value, input logic halfMode);
    ciPkg::word_t swapped;
    int           target;
    for (int i = 0; i < 4; i++) begin
      target = halfMode ? (i ^ 1) : (i ^ 3);
      swapped[8*target +: 8] = value[8*i +: 8];
    end
    return swapped;
  endfunction

  function automatic ciPkg::word_t grayRule(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    return 32'((54 * red + 183 * green + 19 * blue) / 256);
  endfunction

  task automatic runInstruction(input string testName, input ciPkg::opcode_t opcode,
                                input ciPkg::word_t dataA, input ciPkg::word_t dataB,
                                input int holdCycles, output ciPkg::word_t result);
    int waitCount;
    @(posedge s_systemClock);
    ciOpcode <= opcode;
    ciDataA  <= dataA;
    ciDataB  <= dataB;
    ciReq    <= 1'b1;
    waitCount = 0;
    do begin
      @(negedge s_systemClock);
      waitCount++;
    end while (!ciAck && waitCount < ACK_TIMEOUT);
    assert (ciAck) else begin
      $display("%s: ciAck did not rise within %0d cycles", testName, ACK_TIMEOUT);
      abortRun();
    end
    result = ciResult;
    repeat (holdCycles) begin
      @(negedge s_systemClock);
      assert (ciAck) else begin
        $display("%s: ciAck fell while ciReq was still high", testName);
        abortRun();
      end
    end
    @(posedge s_systemClock);
    ciReq <= 1'b0;
    waitCount = 0;
    do begin
      @(negedge s_systemClock);
      waitCount++;
    end while (ciAck && waitCount < ACK_TIMEOUT);
    assert (!ciAck) else begin
      $display("%s: ciAck did not fall within %0d cycles", testName, ACK_TIMEOUT);
      abortRun();
    end
  endtask

  task automatic driveEvents(input int cycles, input logic stall, input logic idle);
    @(posedge s_systemClock);
    cpuStall <= stall;
    busIdle  <= idle;
    repeat (cycles) @(posedge s_systemClock); // sampled high on exactly this many edges.
    cpuStall <= 1'b0;
    busIdle  <= 1'b0;
  endtask

  task automatic checkResetRelease();
    repeat (2) begin
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      checkValue("reset ciAck", 32'd0, 32'(ciAck));
      checkValue("reset peripheralResetN", 32'd0, 32'(peripheralResetN));
      checkValue("reset ciResult", 32'd0, ciResult);
    end
    @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    for (int edgeCount = 1; edgeCount <= 16; edgeCount++) begin
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      checkValue("reset release", 32'(edgeCount == 16), 32'(peripheralResetN));
      checkValue("reset release ciAck", 32'd0, 32'(ciAck));
    end
  endtask

  task automatic sendByteSwaps();
    ciPkg::word_t value;
    ciPkg::word_t modeWord;
    ciPkg::word_t result;
    for (int i = 0; i < 20; i++) begin
      value = $random(seed);
      for (int mode = 0; mode < 2; mode++) begin
        modeWord = $random(seed);
        modeWord[0] = mode[0]; // set picks the half-word swap.
        runInstruction("byte swap", ciPkg::SWAP_ID, value, modeWord, 0, result);
        checkValue("byte swap", swapRule(value, mode[0]), result);
      end
    end
  endtask

  task automatic sendGrayPixels();
    ciPkg::word_t pixelWord;
    ciPkg::word_t result;
    for (int i = 0; i < 22; i++) begin
      pixelWord = $random(seed);
      if (i == 20) pixelWord[15:0] = 16'hffff;
      if (i == 21) pixelWord[15:0] = 16'h0000;
      runInstruction("gray", ciPkg::GRAY_ID, pixelWord, $random(seed), 0, result);
      checkValue("gray", grayRule(pixelWord[15:0]), result);
    end
  endtask

  task automatic exerciseCounters();
    ciPkg::word_t result;
    ciPkg::word_t firstRead;
    int           stallCycles;
    int           idleCycles;
    stallCycles = 1 + int'($unsigned($random(seed)) % 20);
    idleCycles  = 1 + int'($unsigned($random(seed)) % 20);
    runInstruction("stall enable", ciPkg::PROFILE_ID, 32'd1, 32'h202, 0, result);
    checkValue("stall enable", 32'd0, result);
    driveEvents(stallCycles, 1'b1, 1'b0);
    runInstruction("stall count", ciPkg::PROFILE_ID, 32'd1, 32'd0, 0, result);
    checkValue("stall count", 32'(stallCycles), result);
    runInstruction("stall disable", ciPkg::PROFILE_ID, 32'd1, 32'h20, 0, result);
    checkValue("stall disable", 32'(stallCycles), result);
    driveEvents(7, 1'b1, 1'b0); // must not be counted.
    runInstruction("stall frozen", ciPkg::PROFILE_ID, 32'd1, 32'd0, 0, firstRead);
    runInstruction("stall frozen", ciPkg::PROFILE_ID, 32'd1, 32'd0, 0, result);
    checkValue("stall frozen", firstRead, result);
    checkValue("stall frozen", 32'(stallCycles), result);
    runInstruction("stall clear", ciPkg::PROFILE_ID, 32'd1, 32'h200, 0, result);
    checkValue("stall clear", 32'(stallCycles), result);
    runInstruction("stall cleared", ciPkg::PROFILE_ID, 32'd1, 32'd0, 0, result);
    checkValue("stall cleared", 32'd0, result);
    runInstruction("idle enable", ciPkg::PROFILE_ID, 32'd2, 32'h404, 0, result);
    checkValue("idle enable", 32'd0, result);
    driveEvents(5, 1'b1, 1'b0);
    driveEvents(idleCycles, 1'b0, 1'b1);
    runInstruction("idle disable", ciPkg::PROFILE_ID, 32'd2, 32'h40, 0, result);
    checkValue("idle count", 32'(idleCycles), result);
    driveEvents(4, 1'b0, 1'b1);
    runInstruction("idle frozen", ciPkg::PROFILE_ID, 32'd2, 32'd0, 0, result);
    checkValue("idle frozen", 32'(idleCycles), result);
    runInstruction("select 3", ciPkg::PROFILE_ID, 32'd3, 32'd0, 0, result);
    checkValue("select 3", 32'd0, result);
    runInstruction("idle clear", ciPkg::PROFILE_ID, 32'd2, 32'h400, 0, result);
    checkValue("idle clear", 32'(idleCycles), result);
    runInstruction("idle cleared", ciPkg::PROFILE_ID, 32'd2, 32'd0, 0, result);
    checkValue("idle cleared", 32'd0, result);
  endtask

  task automatic probeUnknownOpcode();
    ciPkg::word_t result;
    runInstruction("unknown opcode", 8'h33, $random(seed), $random(seed), 10, result);
    checkValue("unknown opcode", 32'd0, result);
  endtask

  initial begin
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    ciReq         = 1'b0;
    cpuStall      = 1'b0;
    busIdle       = 1'b0;
    ciOpcode      = '0;
    ciDataA       = '0;
    ciDataB       = '0;
    seed          = 32'h292a4dba;
    checkResetRelease();
    sendByteSwaps();
    sendGrayPixels();
    exerciseCounters();
    probeUnknownOpcode();
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== verilog.f ====
ciPkg.sv
ciIssueIf.sv
resetSequencer.sv
profileCounters.sv
ciDecodeStage.sv
ciExecuteStage.sv
ciResponseStage.sv
ciAccelTop.sv
tbCiAccel.sv

// ==== runSim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tbCiAccel
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/VtbCiAccel > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "Everything OK" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
